//--- Makefile
VERILATOR ?= verilator
TOP ?= tbSpi
DUT_TOP ?= spi
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- addressDecoder.sv
`timescale 1ns/1ps

module addressDecoder #(
	parameter spiPkg::peripheralId_t ID = 8'h01
)(
	input spiPkg::busAddr_t address,
	input logic we,
	input logic oe,
	output spiPkg::regAccess_t access [spiPkg::DEVICE_COUNT]
);

	import spiPkg::*;

	peripheralId_t addressId;
	channelIdx_t channel;
	regOffset_t offset;
	logic idMatch;
	logic [DEVICE_COUNT-1:0] hit;

	assign addressId = address[ID_MSB:ID_LSB];
	assign channel = address[CHANNEL_BIT];
	assign offset = address[OFFSET_MSB:OFFSET_LSB];
	assign idMatch = (addressId == ID); // the only place the slot ID is tested.

	always_comb begin
		for (int i = 0; i < DEVICE_COUNT; i++) begin
			hit[i] = idMatch && (channel == channelIdx_t'(i));
			access[i].we = we && hit[i]; // strobes reach the addressed channel only.
			access[i].oe = oe && hit[i];
			access[i].select = hit[i];
			access[i].offset = offset;
		end
	end

endmodule

//--- files.f
spiPkg.sv
addressDecoder.sv
readMux.sv
spiRegisters.sv
spiShifter.sv
spi.sv
spiChecker.sv
tbSpi.sv

//--- readMux.sv
`timescale 1ns/1ps

module readMux (
	input spiPkg::busData_t dataIn [spiPkg::DEVICE_COUNT],
	input logic [spiPkg::DEVICE_COUNT-1:0] requestIn,
	input logic [spiPkg::DEVICE_COUNT-1:0] busyIn,
	output spiPkg::busData_t dataRead,
	output logic requestOutput,
	output logic busy
);

	import spiPkg::*;

	// requests are one-hot, so an AND-OR tree is enough.
	always_comb begin
		dataRead = '0;
		for (int i = 0; i < DEVICE_COUNT; i++) begin
			if (requestIn[i]) begin
				dataRead = dataRead | dataIn[i];
			end
		end
	end

	assign requestOutput = |requestIn;
	assign busy = |busyIn; // any held channel stalls the whole slot.

endmodule

//--- spi.sv
`timescale 1ns/1ps

module spi #(
	parameter spiPkg::peripheralId_t ID = 8'h01
)(
	input logic clk,
	input logic rst,

	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	output logic peripheralBus_busy,
	input spiPkg::busAddr_t peripheralBus_address,
	input spiPkg::byteSel_t peripheralBus_byteSelect,
	output spiPkg::busData_t peripheralBus_dataRead,
	input spiPkg::busData_t peripheralBus_dataWrite,
	output logic requestOutput,

	output logic [spiPkg::DEVICE_COUNT-1:0] spi_en,
	output logic [spiPkg::DEVICE_COUNT-1:0] spi_clk,
	output logic [spiPkg::DEVICE_COUNT-1:0] spi_mosi,
	input logic [spiPkg::DEVICE_COUNT-1:0] spi_miso,
	output logic [spiPkg::DEVICE_COUNT-1:0] spi_cs
);

	import spiPkg::*;

	regAccess_t access [DEVICE_COUNT];
	busData_t channelData [DEVICE_COUNT];
	logic [DEVICE_COUNT-1:0] channelRequest;
	logic [DEVICE_COUNT-1:0] channelBusy;
	spiConfig_t channelConfig [DEVICE_COUNT];
	spiByte_t txByte [DEVICE_COUNT];
	spiByte_t rxByte [DEVICE_COUNT];
	logic [DEVICE_COUNT-1:0] start;
	logic [DEVICE_COUNT-1:0] shifterBusy;
	logic [DEVICE_COUNT-1:0] done;

	// ############################################################
	// Slot decode and read return
	// ############################################################

	addressDecoder #(.ID(ID)) decoder (
		.address(peripheralBus_address),
		.we(peripheralBus_we),
		.oe(peripheralBus_oe),
		.access(access)
	);

	readMux mux (
		.dataIn(channelData),
		.requestIn(channelRequest),
		.busyIn(channelBusy),
		.dataRead(peripheralBus_dataRead),
		.requestOutput(requestOutput),
		.busy(peripheralBus_busy)
	);

	// ############################################################
	// Channels
	// ############################################################

	for (genvar i = 0; i < DEVICE_COUNT; i++) begin : channel
		spiRegisters registers (
			.clk(clk),
			.rst(rst),
			.access(access[i]),
			.byteSelect(peripheralBus_byteSelect),
			.dataWrite(peripheralBus_dataWrite),
			.dataRead(channelData[i]),
			.requestOutput(channelRequest[i]),
			.busy(channelBusy[i]),
			.spiConfig(channelConfig[i]),
			.start(start[i]),
			.txByte(txByte[i]),
			.shifterBusy(shifterBusy[i]),
			.done(done[i]),
			.rxByte(rxByte[i])
		);

		spiShifter shifter (
			.clk(clk),
			.rst(rst),
			.spiConfig(channelConfig[i]),
			.start(start[i]),
			.txByte(txByte[i]),
			.busy(shifterBusy[i]),
			.done(done[i]),
			.rxByte(rxByte[i]),
			.spi_en(spi_en[i]),
			.spi_clk(spi_clk[i]),
			.spi_mosi(spi_mosi[i]),
			.spi_cs(spi_cs[i]),
			.spi_miso(spi_miso[i])
		);
	end

endmodule

//--- spiChecker.sv
`timescale 1ns/1ps

module spiChecker (
	input logic clk,
	input logic rst,
	input logic [spiPkg::DEVICE_COUNT-1:0] spiClk,
	input logic [spiPkg::DEVICE_COUNT-1:0] spiCs,
	input logic requestOutput,
	input logic [spiPkg::DEVICE_COUNT-1:0] channelRequest
);

	import spiPkg::*;

	for (genvar i = 0; i < DEVICE_COUNT; i++) begin : channel
		// a change seen here happened on the previous edge, so compare with cs before it.
		clockInFrame: assert property (@(posedge clk) disable iff (rst)
			(spiClk[i] != $past(spiClk[i])) |-> !$past(spiCs[i]))
			else $error("spi_clk of channel %0d toggled while spi_cs was high", i);
		clockIdleLow: assert property (@(posedge clk) disable iff (rst)
			spiCs[i] |-> !spiClk[i])
			else $error("spi_clk of channel %0d is high while spi_cs is high", i);
	end

	requestPulse: assert property (@(posedge clk) disable iff (rst)
		requestOutput |=> !requestOutput)
		else $error("requestOutput stayed high for more than one cycle");

	oneRequest: assert property (@(posedge clk) disable iff (rst)
		$onehot0(channelRequest))
		else $error("more than one channel answered a read");

endmodule

bind spi spiChecker protocolCheck (
	.clk(clk),
	.rst(rst),
	.spiClk(spi_clk),
	.spiCs(spi_cs),
	.requestOutput(requestOutput),
	.channelRequest(channelRequest)
);

//--- spiPkg.sv
package spiPkg;

	// ############################################################
	// Bus and transfer widths
	// ############################################################

	typedef logic [23:0] busAddr_t;
	typedef logic [31:0] busData_t;
	typedef logic [3:0] byteSel_t;
	typedef logic [7:0] peripheralId_t;
	typedef logic [1:0] regOffset_t;
	typedef logic [0:0] channelIdx_t;
	typedef logic [7:0] spiByte_t;

	localparam int CLOCK_WIDTH = 8;
	typedef logic [CLOCK_WIDTH-1:0] clockDivide_t;

	localparam int DEVICE_COUNT = 2;

	// ############################################################
	// Address fields and register map
	// ############################################################

	localparam int ID_MSB = 23;
	localparam int ID_LSB = 16;
	localparam int CHANNEL_BIT = 4;
	localparam int OFFSET_MSB = 3;
	localparam int OFFSET_LSB = 2;

	localparam regOffset_t REG_CONFIG = 2'd0;
	localparam regOffset_t REG_STATUS = 2'd1;
	localparam regOffset_t REG_DATA = 2'd2; // index 3 is unmapped and reads zero.

	// ############################################################
	// Shared structs
	// ############################################################

	typedef struct packed {
		clockDivide_t clockDivide; // cycles per half period, minus one.
		logic csHold; // keeps chip select low between transfers.
		logic enable; // drives spi_en and gates new transfers.
	} spiConfig_t;

	typedef struct packed {
		logic we;
		logic oe;
		logic select; // only high for the addressed channel.
		regOffset_t offset;
	} regAccess_t;

endpackage

//--- spiRegisters.sv
`timescale 1ns/1ps

module spiRegisters (
	input logic clk,
	input logic rst,
	input spiPkg::regAccess_t access,
	input spiPkg::byteSel_t byteSelect,
	input spiPkg::busData_t dataWrite,
	output spiPkg::busData_t dataRead,
	output logic requestOutput,
	output logic busy,
	output spiPkg::spiConfig_t spiConfig,
	output logic start,
	output spiPkg::spiByte_t txByte,
	input logic shifterBusy,
	input logic done,
	input spiPkg::spiByte_t rxByte
);

	import spiPkg::*;

	logic dataAccess;
	logic writeEn;
	logic readEn;
	logic rxValid;
	spiByte_t lastRx;

	// ############################################################
	// Access decode and back-pressure
	// ############################################################

	assign dataAccess = access.select && (access.offset == REG_DATA);
	assign busy = dataAccess && shifterBusy && (access.we || access.oe); // host must retry.
	assign writeEn = access.select && access.we && !busy;
	assign readEn = access.select && access.oe && !busy;

	// the shifter captures the byte at the same edge as start.
	assign txByte = dataWrite[7:0];
	assign start = writeEn && dataAccess && byteSelect[0] && spiConfig.enable;

	// ############################################################
	// Register state
	// ############################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			spiConfig <= '0;
		end else if (writeEn && access.offset == REG_CONFIG) begin
			if (byteSelect[0]) begin
				spiConfig.enable <= dataWrite[0];
				spiConfig.csHold <= dataWrite[1];
			end
			if (byteSelect[1]) begin
				spiConfig.clockDivide <= dataWrite[15:8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rxValid <= 1'b0;
			lastRx <= '0;
		end else if (done) begin
			rxValid <= 1'b1; // a data read is held off while the shifter is busy.
			lastRx <= rxByte;
		end else if (readEn && dataAccess) begin
			rxValid <= 1'b0;
		end
	end

	// ############################################################
	// Registered read port
	// ############################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			requestOutput <= 1'b0;
		end else begin
			requestOutput <= readEn;
		end
	end

	always_ff @(posedge clk) begin
		if (readEn) begin
			case (access.offset)
				REG_CONFIG: begin
					dataRead <= {16'b0, spiConfig.clockDivide, 6'b0,
						spiConfig.csHold, spiConfig.enable};
				end
				REG_STATUS: begin
					dataRead <= {30'b0, rxValid, shifterBusy};
				end
				REG_DATA: begin
					dataRead <= {24'b0, lastRx};
				end
				default: begin
					dataRead <= '0;
				end
			endcase
		end
	end

endmodule

//--- spiShifter.sv
`timescale 1ns/1ps

module spiShifter (
	input logic clk,
	input logic rst,
	input spiPkg::spiConfig_t spiConfig,
	input logic start,
	input spiPkg::spiByte_t txByte,
	output logic busy,
	output logic done,
	output spiPkg::spiByte_t rxByte,
	output logic spi_en,
	output logic spi_clk,
	output logic spi_mosi,
	output logic spi_cs,
	input logic spi_miso
);

	import spiPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		FINISH
	} shiftState_t;

	localparam logic [3:0] LAST_SHIFT_EDGE = 4'd14; // the last rising edge.

	shiftState_t state;
	clockDivide_t halfCount;
	clockDivide_t divide;
	logic [3:0] edgeCount;
	logic tick;
	spiByte_t txShift;
	spiByte_t rxShift;

	assign tick = (halfCount == '0); // only meaningful outside idle.
	assign busy = (state != IDLE);
	assign done = (state == FINISH) && tick;
	assign rxByte = rxShift;
	assign spi_mosi = txShift[7]; // msb first.
	assign spi_en = spiConfig.enable;

	// ############################################################
	// Transfer sequencing
	// ############################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			halfCount <= '0;
			edgeCount <= '0;
			spi_clk <= 1'b0;
			spi_cs <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= SHIFT;
						halfCount <= spiConfig.clockDivide;
						edgeCount <= '0;
						spi_cs <= 1'b0;
					end else if (!spiConfig.csHold) begin
						spi_cs <= 1'b1;
					end
				end
				SHIFT: begin
					halfCount <= tick ? divide : halfCount - clockDivide_t'(1);
					if (tick) begin
						spi_clk <= !spi_clk;
						edgeCount <= edgeCount + 4'd1;
						if (edgeCount == LAST_SHIFT_EDGE) begin
							state <= FINISH;
						end
					end
				end
				FINISH: begin
					halfCount <= tick ? divide : halfCount - clockDivide_t'(1);
					if (tick) begin
						state <= IDLE; // the final falling edge ends the transfer.
						spi_clk <= 1'b0;
						spi_cs <= !spiConfig.csHold;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ############################################################
	// Shift registers
	// ############################################################

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			txShift <= txByte;
			divide <= spiConfig.clockDivide; // held for the whole transfer.
		end else if (state == SHIFT && tick) begin
			if (spi_clk) begin
				txShift <= {txShift[6:0], 1'b0}; // falling edge presents the next bit.
			end else begin
				rxShift <= {rxShift[6:0], spi_miso}; // rising edge samples miso.
			end
		end
	end

endmodule

//--- tbSpi.sv
`timescale 1ns/1ps

module tbSpi;

	import spiPkg::*;

	localparam peripheralId_t SLOT_ID = 8'h01;
	localparam int TRANSFERS = 20; // split evenly over both channels.
	localparam int TIMEOUT_CYCLES = 64 * (1 + 16 * 256) + 2000;

	logic clk;
	logic rst;
	logic we;
	logic oe;
	logic busy;
	busAddr_t address;
	byteSel_t byteSelect;
	busData_t dataRead;
	busData_t dataWrite;
	logic requestOutput;
	logic [DEVICE_COUNT-1:0] spiEn;
	logic [DEVICE_COUNT-1:0] spiClk;
	logic [DEVICE_COUNT-1:0] spiMosi;
	logic [DEVICE_COUNT-1:0] spiMiso = '0;
	logic [DEVICE_COUNT-1:0] spiCs;

	logic [31:0] lfsr = 32'h9655;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	spiConfig_t configModel [DEVICE_COUNT];
	spiByte_t rxModel [DEVICE_COUNT];
	logic rxValidModel [DEVICE_COUNT];
	spiByte_t slaveTx [DEVICE_COUNT]; // the byte each slave returns, chosen before a transfer.
	spiByte_t slaveRx [DEVICE_COUNT];
	logic [2:0] bitCount [DEVICE_COUNT];
	logic [DEVICE_COUNT-1:0] prevClk = '0;

	spi #(.ID(SLOT_ID)) i_dut (
		.clk(clk),
		.rst(rst),
		.peripheralBus_we(we),
		.peripheralBus_oe(oe),
		.peripheralBus_busy(busy),
		.peripheralBus_address(address),
		.peripheralBus_byteSelect(byteSelect),
		.peripheralBus_dataRead(dataRead),
		.peripheralBus_dataWrite(dataWrite),
		.requestOutput(requestOutput),
		.spi_en(spiEn),
		.spi_clk(spiClk),
		.spi_mosi(spiMosi),
		.spi_miso(spiMiso),
		.spi_cs(spiCs)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// ############################################################
	// Mode-0 slave models
	// ############################################################

	always @(posedge clk) begin
		for (int c = 0; c < DEVICE_COUNT; c++) begin
			if (spiCs[c]) begin
				bitCount[c] = 3'd0;
			end else if (spiClk[c] && !prevClk[c]) begin
				slaveRx[c] = {slaveRx[c][6:0], spiMosi[c]}; // spi_clk rose on the last edge.
				bitCount[c] = bitCount[c] + 3'd1;
			end
			prevClk[c] = spiClk[c];
			spiMiso[c] <= slaveTx[c][3'd7 - bitCount[c]]; // next bit goes out after the sample.
		end
	end

	// ############################################################
	// Stimulus helpers and reference model
	// ############################################################

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrNext(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic busAddr_t regAddress(input peripheralId_t id, input int channel,
		input regOffset_t offset);
		return {id, 11'b0, channel[0], offset, 2'b00};
	endfunction

	function automatic busData_t configWord(input spiConfig_t cfg);
		return {16'b0, cfg.clockDivide, 6'b0, cfg.csHold, cfg.enable};
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic busWrite(input busAddr_t addr, input byteSel_t lanes, input busData_t data);
		logic held;
		held = 1'b1;
		while (held) begin
			we <= 1'b1;
			address <= addr;
			byteSelect <= lanes;
			dataWrite <= data;
			@(posedge clk);
			held = busy; // a refused access is sent again.
			we <= 1'b0;
		end
	endtask

	task automatic busRead(input busAddr_t addr, input logic expectReply, output busData_t data);
		logic held;
		held = 1'b1;
		while (held) begin
			oe <= 1'b1;
			address <= addr;
			@(posedge clk);
			held = busy;
			oe <= 1'b0;
		end
		compareValue("requestOutput", 32'd0, 32'(requestOutput));
		@(posedge clk);
		compareValue("requestOutput", 32'(expectReply), 32'(requestOutput));
		data = dataRead;
	endtask

	task automatic checkRead(input int channel, input regOffset_t offset, input busData_t expected);
		busData_t data;
		busRead(regAddress(SLOT_ID, channel, offset), 1'b1, data);
		compareValue("peripheralBus_dataRead", expected, data);
	endtask

	task automatic writeConfig(input int channel, input byteSel_t lanes, input busData_t data);
		busWrite(regAddress(SLOT_ID, channel, REG_CONFIG), lanes, data);
		if (lanes[0]) begin
			configModel[channel].enable = data[0];
			configModel[channel].csHold = data[1];
		end
		if (lanes[1]) begin
			configModel[channel].clockDivide = data[15:8];
		end
	endtask

	// needs enable set and csHold clear, so that spi_cs marks the end.
	task automatic runTransfer(input int channel, input logic poke);
		spiByte_t tx;
		int count;
		int expectedEnd;
		tx = spiByte_t'(randomBits(8));
		slaveTx[channel] = spiByte_t'(randomBits(8));
		expectedEnd = 1 + 16 * (int'(configModel[channel].clockDivide) + 1);
		busWrite(regAddress(SLOT_ID, channel, REG_DATA), byteSel_t'(randomBits(4)) | 4'b0001,
			{24'(randomBits(24)), tx});
		compareValue("spi_en", 32'd1, 32'(spiEn[channel]));
		count = 1;
		do begin
			if (poke && count == 2) begin
				we <= 1'b1; // a second data write in mid transfer must bounce.
				address <= regAddress(SLOT_ID, channel, REG_DATA);
				dataWrite <= {24'b0, ~tx};
			end
			@(posedge clk);
			count++;
			if (poke && count == 3) begin
				compareValue("peripheralBus_busy", 32'd1, 32'(busy));
				we <= 1'b0;
			end
		end while (!spiCs[channel]);
		compareValue("spi_cs rise cycle", 32'(expectedEnd), 32'(count - 1));
		compareValue("spi_mosi byte", 32'(tx), 32'(slaveRx[channel]));
		rxModel[channel] = slaveTx[channel];
		rxValidModel[channel] = 1'b1;
		checkRead(channel, REG_STATUS, {30'b0, rxValidModel[channel], 1'b0});
		checkRead(channel, REG_DATA, {24'b0, rxModel[channel]});
		rxValidModel[channel] = 1'b0;
		checkRead(channel, REG_STATUS, 32'd0);
	endtask

	// ############################################################
	// Test sequence
	// ############################################################

	initial begin
		busData_t data;
		int channel;
		peripheralId_t otherId;
		spiByte_t tx;
		rst = 1'b1;
		we = 1'b0;
		oe = 1'b0;
		address = '0;
		byteSelect = '0;
		dataWrite = '0;
		for (int c = 0; c < DEVICE_COUNT; c++) begin
			configModel[c] = '0;
			rxModel[c] = '0;
			rxValidModel[c] = 1'b0;
			slaveTx[c] = '0;
			slaveRx[c] = '0;
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		compareValue("spi_cs", 32'h3, 32'(spiCs));
		compareValue("spi_clk", 32'h0, 32'(spiClk));
		compareValue("spi_en", 32'h0, 32'(spiEn));
		compareValue("requestOutput", 32'h0, 32'(requestOutput));
		for (int c = 0; c < DEVICE_COUNT; c++) begin
			checkRead(c, REG_CONFIG, 32'd0);
			checkRead(c, REG_STATUS, 32'd0);
		end

		repeat (16) begin
			channel = int'(randomBits(1));
			writeConfig(channel, byteSel_t'(randomBits(4)), randomBits(32));
			checkRead(channel, REG_CONFIG, configWord(configModel[channel]));
		end
		repeat (4) begin
			otherId = peripheralId_t'(randomBits(8));
			if (otherId == SLOT_ID) begin
				otherId = ~SLOT_ID;
			end
			channel = int'(randomBits(1));
			busWrite(regAddress(otherId, channel, REG_CONFIG), 4'hf, randomBits(32));
			busRead(regAddress(otherId, channel, REG_CONFIG), 1'b0, data);
			checkRead(channel, REG_CONFIG, configWord(configModel[channel]));
		end

		for (int n = 0; n < TRANSFERS; n++) begin
			channel = n % DEVICE_COUNT;
			writeConfig(channel, 4'b0011, {16'b0, 8'(randomBits(8)), 8'h01});
			runTransfer(channel, n[2]);
		end

		writeConfig(0, 4'b0001, 32'd0);
		busWrite(regAddress(SLOT_ID, 0, REG_DATA), 4'b0001, 32'h5a);
		repeat (20) begin
			@(posedge clk);
			compareValue("spi_cs", 32'd1, 32'(spiCs[0]));
		end
		checkRead(0, REG_STATUS, 32'd0);
		compareValue("spi_en", 32'd0, 32'(spiEn[0]));

		writeConfig(1, 4'b0011, {16'b0, 8'(randomBits(4)), 8'h03});
		tx = spiByte_t'(randomBits(8));
		slaveTx[1] = spiByte_t'(randomBits(8));
		busWrite(regAddress(SLOT_ID, 1, REG_DATA), 4'b0001, {24'b0, tx});
		do begin
			busRead(regAddress(SLOT_ID, 1, REG_STATUS), 1'b1, data);
		end while (data[0]);
		compareValue("spi_cs", 32'd0, 32'(spiCs[1]));
		compareValue("spi_mosi byte", 32'(tx), 32'(slaveRx[1]));
		checkRead(1, REG_DATA, {24'b0, slaveTx[1]});
		writeConfig(1, 4'b0001, 32'h1);
		repeat (2) @(posedge clk); // the idle FSM releases spi_cs one cycle after the write.
		compareValue("spi_cs", 32'd1, 32'(spiCs[1]));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
